/* uart_bridge_consts.svh */
`ifndef UART_BRIDGE_CONSTS_SVH
`define UART_BRIDGE_CONSTS_SVH

// serial timing, clocks per bit (kept short for simulation)
`define UART_CLKS_PER_BIT 8

// register map of the uart core
`define UART_ADDR_RX   2'd0  // rx holding register, read clears valid
`define UART_ADDR_TX   2'd1  // tx holding register, write starts frame
`define UART_ADDR_STAT 2'd2  // status register

// status bit positions
`define UART_STAT_RXV 0  // rx byte waiting
`define UART_STAT_TXF 3  // tx busy until stop bit ends

// stream word geometry
`define WORD_BYTES 8

`endif

/* uart_reg_pkg.sv */
package uart_reg_pkg;

`include "uart_bridge_consts.svh"

  // register select on the core bus
  typedef enum logic [1:0] {
    REG_RX   = `UART_ADDR_RX,
    REG_TX   = `UART_ADDR_TX,
    REG_STAT = `UART_ADDR_STAT
  } uart_reg_e;

  // register data, one byte wide
  typedef logic [7:0] reg_byte_t;

endpackage

/* uart_stream_pkg.sv */
package uart_stream_pkg;

`include "uart_bridge_consts.svh"

  // controller phases
  typedef enum logic [2:0] {
    WAIT,      // idle, polling status
    ING_STAT,  // waiting for next rx byte
    ING_DATA,  // reading rx byte
    EGR_STAT,  // waiting for tx not full
    EGR_DATA   // writing tx byte
  } bridge_state_e;

  typedef logic [`WORD_BYTES*8-1:0] word_t;  // stream data word

  typedef logic [$clog2(`WORD_BYTES)-1:0] byte_mod_t;  // valid bytes, 0 means all

endpackage

/* uart_lite.sv */
`timescale 1ns/100ps

`include "uart_bridge_consts.svh"

module uart_lite (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_rx_uart,
  output logic                    o_tx_uart,
  input  logic                    i_bus_val,
  output logic                    o_bus_rdy,
  input  logic                    i_bus_wr,
  input  uart_reg_pkg::uart_reg_e i_bus_addr,
  input  uart_reg_pkg::reg_byte_t i_bus_wdat,
  output logic                    o_bus_rval,
  output uart_reg_pkg::reg_byte_t o_bus_rdat
);
  import uart_reg_pkg::*;

  localparam int CLKS = `UART_CLKS_PER_BIT;
  localparam int CW   = $clog2(CLKS);

  logic          bus_acc;
  reg_byte_t     stat;
  logic [1:0]    rx_s;       // rx synchroniser
  logic          rx_busy;
  logic [CW-1:0] rx_cnt;
  logic [3:0]    rx_bits;    // 0 start, 1..8 data, 9 stop
  logic [7:0]    rx_shift;
  reg_byte_t     rx_hold;
  logic          rx_valid;
  logic [9:0]    tx_shift;   // stop, data, start
  logic [CW-1:0] tx_cnt;
  logic [3:0]    tx_bits;    // bits left in frame
  logic          tx_full;

  assign o_bus_rdy = !o_bus_rval;  // one read in flight
  assign bus_acc   = i_bus_val && o_bus_rdy;
  assign o_tx_uart = tx_shift[0];

  always_comb begin
    stat = '0;
    stat[`UART_STAT_RXV] = rx_valid;
    stat[`UART_STAT_TXF] = tx_full;
  end

  // register bus, read data one cycle after accept
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_bus_rval <= 1'b0;
    end else begin
      o_bus_rval <= bus_acc && !i_bus_wr;
    end
    case (i_bus_addr)
      REG_RX:   o_bus_rdat <= rx_hold;
      REG_STAT: o_bus_rdat <= stat;
      default:  o_bus_rdat <= '0;  // tx reads back zero
    endcase
  end

  // receiver, samples each bit in its middle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rx_s     <= 2'b11;
      rx_busy  <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      rx_s <= {rx_s[0], i_rx_uart};
      if (bus_acc && !i_bus_wr && i_bus_addr == REG_RX) rx_valid <= 1'b0;  // read clears
      if (!rx_busy) begin
        if (!rx_s[1]) begin  // start edge
          rx_busy <= 1'b1;
          rx_cnt  <= CW'(CLKS / 2 - 1);
          rx_bits <= 4'd0;
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        rx_cnt  <= CW'(CLKS - 1);
        rx_bits <= rx_bits + 4'd1;
        if (rx_bits == 4'd0) begin
          if (rx_s[1]) rx_busy <= 1'b0;  // glitch, not a start bit
        end else if (rx_bits == 4'd9) begin
          rx_busy <= 1'b0;
          if (rx_s[1]) begin  // good stop bit
            rx_hold  <= rx_shift;
            rx_valid <= 1'b1;
          end
        end else begin
          rx_shift <= {rx_s[1], rx_shift[7:1]};  // lsb first
        end
      end
    end
  end

  // transmitter, full stays set through the stop bit
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      tx_shift <= '1;  // line idles high
      tx_full  <= 1'b0;
    end else if (bus_acc && i_bus_wr && i_bus_addr == REG_TX && !tx_full) begin
      tx_shift <= {1'b1, i_bus_wdat, 1'b0};
      tx_cnt   <= CW'(CLKS - 1);
      tx_bits  <= 4'd10;
      tx_full  <= 1'b1;
    end else if (tx_full) begin
      if (tx_cnt != '0) begin
        tx_cnt <= tx_cnt - 1'b1;
      end else begin
        tx_cnt   <= CW'(CLKS - 1);
        tx_shift <= {1'b1, tx_shift[9:1]};
        tx_bits  <= tx_bits - 4'd1;
        if (tx_bits == 4'd1) tx_full <= 1'b0;  // stop bit done
      end
    end
  end

  // controller must poll status before every tx write
  a_no_tx_overrun: assert property (@(posedge i_clk) disable iff (i_rst)
    (bus_acc && i_bus_wr && i_bus_addr == REG_TX) |-> !tx_full);

endmodule

/* uart_stream_ctrl.sv */
`timescale 1ns/100ps

`include "uart_bridge_consts.svh"

module uart_stream_ctrl (
  input  logic                    i_clk,
  input  logic                    i_rst,
  output logic                    o_bus_val,
  input  logic                    i_bus_rdy,
  output logic                    o_bus_wr,
  output uart_reg_pkg::uart_reg_e o_bus_addr,
  output uart_reg_pkg::reg_byte_t o_bus_wdat,
  input  logic                    i_bus_rval,
  input  uart_reg_pkg::reg_byte_t i_bus_rdat,
  output logic                    o_byt_val,
  input  logic                    i_byt_rdy,
  output logic [7:0]              o_byt_dat,
  output logic                    o_byt_sop,
  output logic                    o_byt_eop,
  input  logic                    i_egr_byt_val,
  output logic                    o_egr_byt_rdy,
  input  logic [7:0]              i_egr_byt_dat,
  input  logic                    i_egr_byt_eop
);
  import uart_reg_pkg::*;
  import uart_stream_pkg::*;

  bridge_state_e state;
  logic          bus_acc;
  logic          bus_free;   // no request out, no read pending
  logic          poll_en;
  logic          pend;       // read accepted last cycle
  logic          egr_last;   // eop byte being written
  logic          rsp_eop;
  logic [15:0]   byt_cnt;    // ingress byte index
  logic [15:0]   pkt_len;    // length header
  logic [15:0]   hdr_len;

  assign bus_acc  = o_bus_val && i_bus_rdy;
  assign bus_free = !o_bus_val && !pend;
  // no poll during tx write, no rx read while a byte is pending
  assign poll_en  = (state != EGR_DATA) && !(state == ING_DATA && o_byt_val);

  // eop decode for the byte coming back on the bus
  always_comb begin
    hdr_len = {i_bus_rdat, pkt_len[7:0]};
    if (byt_cnt == 16'd0) begin
      rsp_eop = 1'b0;
    end else if (byt_cnt == 16'd1) begin
      rsp_eop = (hdr_len <= 16'd2);  // short header counts as 2
    end else begin
      rsp_eop = ((byt_cnt + 16'd1) >= pkt_len);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= WAIT;
      o_bus_val     <= 1'b0;
      o_bus_wr      <= 1'b0;
      pend          <= 1'b0;
      o_byt_val     <= 1'b0;
      o_egr_byt_rdy <= 1'b0;
      byt_cnt       <= '0;
    end else begin
      pend <= bus_acc && !o_bus_wr;
      if (bus_acc) o_bus_val <= 1'b0;
      if (o_byt_val && i_byt_rdy) o_byt_val <= 1'b0;

      if (bus_free && poll_en) begin  // next read, rx data or status
        o_bus_val  <= 1'b1;
        o_bus_wr   <= 1'b0;
        o_bus_addr <= (state == ING_DATA) ? REG_RX : REG_STAT;
      end

      case (state)
        WAIT: begin
          if (i_bus_rval) begin
            if (i_bus_rdat[`UART_STAT_RXV]) state <= ING_DATA;  // host first
            else if (i_egr_byt_val) state <= EGR_STAT;
          end
        end
        ING_STAT: begin
          if (i_bus_rval && i_bus_rdat[`UART_STAT_RXV]) state <= ING_DATA;
        end
        ING_DATA: begin
          if (i_bus_rval) begin
            o_byt_val <= 1'b1;
            o_byt_dat <= i_bus_rdat;
            o_byt_sop <= (byt_cnt == 16'd0);
            o_byt_eop <= rsp_eop;
            if (byt_cnt == 16'd0) pkt_len[7:0] <= i_bus_rdat;   // length lo
            if (byt_cnt == 16'd1) pkt_len[15:8] <= i_bus_rdat;  // length hi
            if (rsp_eop) begin
              byt_cnt <= '0;
              state   <= WAIT;
            end else begin
              byt_cnt <= byt_cnt + 16'd1;
              state   <= ING_STAT;
            end
          end
        end
        EGR_STAT: begin
          if (i_bus_rval && !i_bus_rdat[`UART_STAT_TXF]) begin
            o_egr_byt_rdy <= 1'b1;  // room for one byte
            state         <= EGR_DATA;
          end
        end
        EGR_DATA: begin
          if (i_egr_byt_val && o_egr_byt_rdy) begin
            o_egr_byt_rdy <= 1'b0;
            o_bus_val     <= 1'b1;
            o_bus_wr      <= 1'b1;
            o_bus_addr    <= REG_TX;
            o_bus_wdat    <= i_egr_byt_dat;
            egr_last      <= i_egr_byt_eop;
          end
          if (bus_acc && o_bus_wr) state <= egr_last ? WAIT : EGR_STAT;
        end
        default: state <= WAIT;
      endcase
    end
  end

  // held byte must survive packer back-pressure
  a_byt_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_byt_val && !i_byt_rdy) |=> (o_byt_val && $stable(o_byt_dat)));

endmodule

/* byte_packer.sv */
`timescale 1ns/100ps

`include "uart_bridge_consts.svh"

module byte_packer (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_byt_val,
  output logic                    o_byt_rdy,
  input  logic [7:0]              i_byt_dat,
  input  logic                    i_byt_sop,
  input  logic                    i_byt_eop,
  output logic                    o_ing_val,
  input  logic                    i_ing_rdy,
  output uart_stream_pkg::word_t     o_ing_dat,
  output logic                    o_ing_sop,
  output logic                    o_ing_eop,
  output uart_stream_pkg::byte_mod_t o_ing_mod
);
  import uart_stream_pkg::*;

  word_t     acc;        // partial word, unused lanes zero
  word_t     nxt;
  byte_mod_t lane;       // next free lane
  logic      acc_sop;
  logic      nxt_sop;
  logic      byt_acc;
  logic      word_done;

  assign o_byt_rdy = !o_ing_val;  // stall while a word is held
  assign byt_acc   = i_byt_val && o_byt_rdy;
  assign word_done = i_byt_eop || (lane == byte_mod_t'(`WORD_BYTES - 1));

  always_comb begin
    nxt = acc;
    nxt[lane*8 +: 8] = i_byt_dat;
    nxt_sop = (lane == '0) ? i_byt_sop : acc_sop;  // sop from lane 0 byte
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ing_val <= 1'b0;
      lane      <= '0;
      acc       <= '0;
    end else begin
      if (o_ing_val && i_ing_rdy) o_ing_val <= 1'b0;
      if (byt_acc) begin
        if (word_done) begin
          o_ing_val <= 1'b1;
          o_ing_dat <= nxt;
          o_ing_sop <= nxt_sop;
          o_ing_eop <= i_byt_eop;
          o_ing_mod <= byte_mod_t'(lane + 1'b1);  // wraps to 0 on full word
          lane      <= '0;
          acc       <= '0;
        end else begin
          acc     <= nxt;
          acc_sop <= nxt_sop;
          lane    <= lane + 1'b1;
        end
      end
    end
  end

  // a new packet must start on a word boundary
  a_sop_lane0: assert property (@(posedge i_clk) disable iff (i_rst)
    (byt_acc && i_byt_sop) |-> (lane == '0));

endmodule

/* byte_unpacker.sv */
`timescale 1ns/100ps

module byte_unpacker (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_egr_val,
  output logic                       o_egr_rdy,
  input  uart_stream_pkg::word_t     i_egr_dat,
  input  logic                       i_egr_eop,
  input  uart_stream_pkg::byte_mod_t i_egr_mod,
  output logic                       o_byt_val,
  input  logic                       i_byt_rdy,
  output logic [7:0]                 o_byt_dat,
  output logic                       o_byt_eop
);
  import uart_stream_pkg::*;

  word_t     word_q;
  logic      eop_q;
  byte_mod_t mod_q;
  byte_mod_t lane;       // lane being offered
  byte_mod_t last_lane;
  logic      full;

  // short last word stops at mod-1, all others run to lane 7
  assign last_lane = (eop_q && mod_q != '0) ? byte_mod_t'(mod_q - 1'b1) : '1;
  assign o_byt_val = full;
  assign o_byt_dat = word_q[lane*8 +: 8];
  assign o_byt_eop = eop_q && (lane == last_lane);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      full      <= 1'b0;
      o_egr_rdy <= 1'b0;
      lane      <= '0;
    end else begin
      if (i_egr_val && o_egr_rdy) begin  // load new word
        word_q    <= i_egr_dat;
        eop_q     <= i_egr_eop;
        mod_q     <= i_egr_mod;
        lane      <= '0;
        full      <= 1'b1;
        o_egr_rdy <= 1'b0;
      end else if (!full) begin
        o_egr_rdy <= 1'b1;  // first cycle out of reset
      end
      if (full && i_byt_rdy) begin
        if (lane == last_lane) begin
          full      <= 1'b0;
          o_egr_rdy <= 1'b1;  // ready again with no bubble
        end else begin
          lane <= lane + 1'b1;
        end
      end
    end
  end

endmodule

/* uart_bridge.sv */
`timescale 1ns/100ps

module uart_bridge (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_rx_uart,
  output logic                       o_tx_uart,
  output logic                       o_ing_val,
  input  logic                       i_ing_rdy,
  output uart_stream_pkg::word_t     o_ing_dat,
  output logic                       o_ing_sop,
  output logic                       o_ing_eop,
  output uart_stream_pkg::byte_mod_t o_ing_mod,
  input  logic                       i_egr_val,
  output logic                       o_egr_rdy,
  input  uart_stream_pkg::word_t     i_egr_dat,
  input  logic                       i_egr_eop,
  input  uart_stream_pkg::byte_mod_t i_egr_mod
);
  import uart_reg_pkg::*;

  // register bus
  logic       bus_val, bus_rdy, bus_wr, bus_rval;
  uart_reg_e  bus_addr;
  reg_byte_t  bus_wdat, bus_rdat;
  // ingress bytes, controller to packer
  logic       ib_val, ib_rdy, ib_sop, ib_eop;
  logic [7:0] ib_dat;
  // egress bytes, unpacker to controller
  logic       eb_val, eb_rdy, eb_eop;
  logic [7:0] eb_dat;

  uart_lite uart0 (
    .i_clk, .i_rst, .i_rx_uart, .o_tx_uart,
    .i_bus_val(bus_val), .o_bus_rdy(bus_rdy), .i_bus_wr(bus_wr), .i_bus_addr(bus_addr),
    .i_bus_wdat(bus_wdat), .o_bus_rval(bus_rval), .o_bus_rdat(bus_rdat));

  uart_stream_ctrl ctrl0 (
    .i_clk, .i_rst,
    .o_bus_val(bus_val), .i_bus_rdy(bus_rdy), .o_bus_wr(bus_wr), .o_bus_addr(bus_addr),
    .o_bus_wdat(bus_wdat), .i_bus_rval(bus_rval), .i_bus_rdat(bus_rdat),
    .o_byt_val(ib_val), .i_byt_rdy(ib_rdy), .o_byt_dat(ib_dat), .o_byt_sop(ib_sop),
    .o_byt_eop(ib_eop), .i_egr_byt_val(eb_val), .o_egr_byt_rdy(eb_rdy),
    .i_egr_byt_dat(eb_dat), .i_egr_byt_eop(eb_eop));

  byte_packer pack0 (
    .i_clk, .i_rst, .i_byt_val(ib_val), .o_byt_rdy(ib_rdy), .i_byt_dat(ib_dat),
    .i_byt_sop(ib_sop), .i_byt_eop(ib_eop), .o_ing_val, .i_ing_rdy, .o_ing_dat,
    .o_ing_sop, .o_ing_eop, .o_ing_mod);

  byte_unpacker unpack0 (
    .i_clk, .i_rst, .i_egr_val, .o_egr_rdy, .i_egr_dat, .i_egr_eop, .i_egr_mod,
    .o_byt_val(eb_val), .i_byt_rdy(eb_rdy), .o_byt_dat(eb_dat), .o_byt_eop(eb_eop));

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 2,  // 4 ns clock
  parameter int RST_CYCLES  = 8
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;  // drops on a rising edge
  end

endmodule

/* tb_uart_bridge.sv */
`timescale 1ns/100ps

`include "uart_bridge_consts.svh"

module tb_uart_bridge;
  import uart_reg_pkg::*;
  import uart_stream_pkg::*;

  localparam int CLKS  = `UART_CLKS_PER_BIT;
  localparam int LIMIT = 6000;  // cycles per wait loop

  typedef enum logic [1:0] {DIR_ING, DIR_EGR, DIR_BOTH} dir_e;
  typedef struct packed {
    dir_e        dir;
    logic [15:0] len;  // header value, or egress byte count
    logic        bp;   // random stalls on i_ing_rdy
  } row_t;

  logic      clk, rst;
  logic      rx_uart, tx_uart;
  logic      ing_val, ing_rdy, ing_sop, ing_eop;
  word_t     ing_dat;
  byte_mod_t ing_mod;
  logic      egr_val, egr_rdy, egr_eop;
  word_t     egr_dat;
  byte_mod_t egr_mod;

  row_t      tests [6];
  reg_byte_t ing_q [$];  // host bytes, header first
  reg_byte_t egr_q [$];  // fabric payload
  integer    seed = 87466;
  int        checks, errs, timed_out;

  tb_clk_gen clk0 (.o_clk(clk), .o_rst(rst));

  uart_bridge dut0 (
    .i_clk(clk), .i_rst(rst), .i_rx_uart(rx_uart), .o_tx_uart(tx_uart),
    .o_ing_val(ing_val), .i_ing_rdy(ing_rdy), .o_ing_dat(ing_dat), .o_ing_sop(ing_sop),
    .o_ing_eop(ing_eop), .o_ing_mod(ing_mod), .i_egr_val(egr_val), .o_egr_rdy(egr_rdy),
    .i_egr_dat(egr_dat), .i_egr_eop(egr_eop), .i_egr_mod(egr_mod));

  task automatic word_eq(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic mod_eq(input string name, input byte_mod_t got, input byte_mod_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic flag_eq(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic serial_byte_eq(input string name, input reg_byte_t got, input reg_byte_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errs++;
    timed_out = 1;
    $display("timeout at %0t, %s", $time, what);
  endtask

  task automatic build_payload(input row_t r);
    int n;
    int k;
    ing_q.delete();
    egr_q.delete();
    n = (r.len < 16'd2) ? 2 : int'(r.len);  // short header still frames 2 bytes
    ing_q.push_back(r.len[7:0]);
    ing_q.push_back(r.len[15:8]);
    for (k = 2; k < n; k++) ing_q.push_back(8'($random(seed)));
    for (k = 0; k < int'(r.len); k++) egr_q.push_back(8'($random(seed)));
  endtask

  // word w of the ingress packet as the fabric should see it
  function automatic word_t expected_word(input int w);
    word_t d;
    int k;
    d = '0;
    for (k = 0; k < `WORD_BYTES; k++) begin
      if (w * 8 + k < ing_q.size()) d[k*8 +: 8] = ing_q[w * 8 + k];
    end
    return d;
  endfunction

  task automatic drive_rx_byte(input reg_byte_t b);
    logic [9:0] frame;
    int k;
    frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
    for (k = 0; k < 10; k++) begin
      @(posedge clk);
      rx_uart <= frame[k];
      repeat (CLKS - 1) @(posedge clk);
    end
  endtask

  task automatic host_packet();
    int k;
    for (k = 0; k < ing_q.size(); k++) drive_rx_byte(ing_q[k]);
  endtask

  task automatic collect_ing(input logic bp);
    int w;
    int cyc;
    int last;
    last = (ing_q.size() - 1) / `WORD_BYTES;  // eop word index
    w = 0;
    cyc = 0;
    while (w <= last && cyc < LIMIT) begin
      @(posedge clk);
      ing_rdy <= bp ? 1'($random(seed)) : 1'b1;
      @(negedge clk);
      cyc++;
      if (ing_val && ing_rdy) begin  // taken at next edge
        word_eq("o_ing_dat", ing_dat, expected_word(w));
        flag_eq("o_ing_sop", ing_sop, w == 0);
        flag_eq("o_ing_eop", ing_eop, w == last);
        mod_eq("o_ing_mod", ing_mod,
          (w == last) ? byte_mod_t'(ing_q.size() % `WORD_BYTES) : byte_mod_t'(0));
        w++;
      end
    end
    @(posedge clk);
    ing_rdy <= 1'b0;
    if (w <= last) report_timeout("ingress words missing on o_ing_val");
  endtask

  task automatic feed_egress();
    int nw;
    int w;
    int k;
    int cyc;
    logic took;
    word_t d;
    nw = (egr_q.size() + `WORD_BYTES - 1) / `WORD_BYTES;
    for (w = 0; w < nw; w++) begin
      for (k = 0; k < `WORD_BYTES; k++) begin
        d[k*8 +: 8] = (w * 8 + k < egr_q.size()) ? egr_q[w * 8 + k] : 8'($random(seed));
      end
      @(posedge clk);
      egr_val <= 1'b1;
      egr_dat <= d;
      egr_eop <= (w == nw - 1);
      egr_mod <= (w == nw - 1) ? byte_mod_t'(egr_q.size() % `WORD_BYTES) : byte_mod_t'(0);
      cyc = 0;
      @(negedge clk);
      while (!egr_rdy && cyc < LIMIT) begin
        @(negedge clk);
        cyc++;
      end
      took = egr_rdy;  // word moves at the coming edge
      @(posedge clk);
      egr_val <= 1'b0;
      if (!took) begin
        report_timeout("o_egr_rdy never rose for the next word");
        break;
      end
    end
  endtask

  task automatic decode_tx();
    int k;
    int b;
    int cyc;
    logic extra;
    reg_byte_t got;
    extra = 1'b0;
    for (k = 0; k < egr_q.size(); k++) begin
      cyc = 0;
      while (tx_uart && cyc < LIMIT) begin
        @(negedge clk);
        cyc++;
      end
      if (tx_uart) begin
        report_timeout("no start bit on o_tx_uart");
        break;
      end
      repeat (CLKS / 2) @(negedge clk);  // middle of start bit
      flag_eq("o_tx_uart start bit", tx_uart, 1'b0);
      for (b = 0; b < 8; b++) begin
        repeat (CLKS) @(negedge clk);
        got[b] = tx_uart;
      end
      repeat (CLKS) @(negedge clk);
      flag_eq("o_tx_uart stop bit", tx_uart, 1'b1);
      serial_byte_eq("o_tx_uart", got, egr_q[k]);
    end
    for (cyc = 0; cyc < 20 * CLKS; cyc++) begin  // line stays idle after the packet
      @(negedge clk);
      if (!tx_uart && !extra) begin
        extra = 1'b1;
        errs++;
        $display("unexpected start bit on o_tx_uart after the packet at %0t", $time);
      end
    end
  endtask

  initial begin
    int i;
    int errs_before;
    int cyc;
    rx_uart   = 1'b1;
    ing_rdy   = 1'b0;
    egr_val   = 1'b0;
    egr_dat   = '0;
    egr_eop   = 1'b0;
    egr_mod   = '0;
    checks    = 0;
    errs      = 0;
    timed_out = 0;
    tests[0] = '{DIR_ING, 16'd10, 1'b0};   // two words, mod 2
    tests[1] = '{DIR_ING, 16'd1, 1'b0};    // short header
    tests[2] = '{DIR_ING, 16'd16, 1'b1};   // full last word under stalls
    tests[3] = '{DIR_EGR, 16'd11, 1'b0};   // last word mod 3
    tests[4] = '{DIR_EGR, 16'd16, 1'b0};
    tests[5] = '{DIR_BOTH, 16'd12, 1'b1};  // ingress then egress at once
    repeat (4) @(negedge clk);  // still in reset
    flag_eq("o_tx_uart", tx_uart, 1'b1);
    flag_eq("o_ing_val", ing_val, 1'b0);
    flag_eq("o_egr_rdy", egr_rdy, 1'b0);
    cyc = 0;
    while (rst && cyc < LIMIT) begin
      @(negedge clk);
      cyc++;
    end
    if (rst) report_timeout("reset never released");
    $display("test 0 reset levels: %s", (errs == 0) ? "ok" : "failed");
    for (i = 0; i < 6 && !timed_out; i++) begin
      errs_before = errs;
      build_payload(tests[i]);
      repeat (10) @(posedge clk);
      case (tests[i].dir)
        DIR_ING: begin
          fork
            host_packet();
            collect_ing(tests[i].bp);
          join
        end
        DIR_EGR: begin
          fork
            feed_egress();
            decode_tx();
          join
        end
        default: begin
          fork
            begin
              host_packet();
              feed_egress();  // right behind the last host byte
            end
            collect_ing(tests[i].bp);
            decode_tx();
          join
        end
      endcase
      $display("test %0d %s len %0d: %s", i + 1, tests[i].dir.name(), tests[i].len,
        (errs == errs_before) ? "ok" : "failed");
    end
    $display("tests run %0d, checks %0d, errors %0d", i + 1, checks, errs);
    if (errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* uart_bridge.f */
+incdir+.
uart_reg_pkg.sv
uart_stream_pkg.sv
uart_lite.sv
uart_stream_ctrl.sv
byte_packer.sv
byte_unpacker.sv
uart_bridge.sv
tb_clk_gen.sv
tb_uart_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, then look for the fail line in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f uart_bridge.f \
  --top-module tb_uart_bridge -o tb_uart_bridge > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_uart_bridge 2>&1 | tee sim.log \
  || { echo "simulation did not complete"; exit 1; }
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
